// File: mem_geometry_pkg.sv
//######################################
// Geometry of the memory array. Bank count defaults only,
// the top level overrides NUM_BANKS and BANK_SEL_BITS
//######################################

package mem_geometry_pkg;

  // One chip holds 16K single-bit cells
  localparam int CHIP_ADDR_BITS = 14;                  // Address pins per chip
  localparam int CHIP_DEPTH     = 2 ** CHIP_ADDR_BITS; // Cells per chip

  // Bank selection sits above the chip address
  localparam int NUM_BANKS_DEFAULT     = 4; // 1, 2, 4 or 8 supported
  localparam int BANK_SEL_BITS_DEFAULT = 2; // Must cover NUM_BANKS

  // Address as seen by a single chip
  typedef logic [CHIP_ADDR_BITS-1:0] chip_addr_t;

endpackage

// File: mem_word_pkg.sv
//######################################
// Word layout. 16 data bits plus one odd parity bit,
// parity lives in the top chip of each bank
//######################################

package mem_word_pkg;

  localparam int WORD_BITS   = 16;            // User data width
  localparam int STORED_BITS = WORD_BITS + 1; // Chips per bank
  localparam int PARITY_POS  = WORD_BITS;     // Parity chip index

  // Data word as seen on the user side
  typedef logic [WORD_BITS-1:0] word_t;

  // Word as held in the array, parity on top
  typedef logic [STORED_BITS-1:0] stored_word_t;

endpackage

// File: static_ram_16kx1.sv
//######################################
// 16K x 1 SRAM, controls active low. Contents undefined
// until written, q reads 0 unless enabled for read
//######################################
`timescale 1ns/1ps

module static_ram_16kx1 (
  input  logic                        clk,
  input  logic                        reset_n,
  input  mem_geometry_pkg::chip_addr_t address,
  input  logic                        ce_n,     // Chip enable
  input  logic                        d,        // Write data
  input  logic                        w_n,      // Write enable
  output logic                        q         // Gated read data
);

  import mem_geometry_pkg::*;

  logic mem_array [0:CHIP_DEPTH-1]; // Cell array, no reset
  logic data_out;                   // Registered read bit

  // Cells only, a write or read needs the chip enabled
  always_ff @(posedge clk) begin
    if (reset_n && !ce_n && !w_n) begin
      mem_array[address] <= d;
    end
  end

  // Read register, held clear while in reset
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      data_out <= 1'b0;
    end else if (!ce_n && w_n) begin
      data_out <= mem_array[address]; // Read cycle
    end
  end

  // Output drives 0 when deselected or writing, so banks can be ORed
  assign q = (!ce_n && w_n) ? data_out : 1'b0;

endmodule

// File: memory_bank_array.sv
//######################################
// NUM_BANKS banks of 17 one-bit chips. bank_sel values
// beyond NUM_BANKS select nothing and read as 0
//######################################
`timescale 1ns/1ps

module memory_bank_array #(
  parameter int NUM_BANKS     = mem_geometry_pkg::NUM_BANKS_DEFAULT,
  parameter int BANK_SEL_BITS = mem_geometry_pkg::BANK_SEL_BITS_DEFAULT
) (
  input  logic                          clk,
  input  logic                          reset_n,
  input  mem_geometry_pkg::chip_addr_t  chip_addr,  // Shared by every chip
  input  logic [BANK_SEL_BITS-1:0]      bank_sel,   // Which bank sees ce_n
  input  logic                          ce_n,       // Common chip enable
  input  logic                          w_n,        // Common write enable
  input  mem_word_pkg::stored_word_t    store_data, // One bit per chip
  output mem_word_pkg::stored_word_t    load_data   // Selected bank output
);

  import mem_word_pkg::*;

  logic         bank_ce_n [NUM_BANKS]; // Decoded enable per bank
  stored_word_t bank_q    [NUM_BANKS]; // Gated output of each bank

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank

    // Only the addressed bank gets the enable
    assign bank_ce_n[b] = ce_n | (bank_sel != BANK_SEL_BITS'(b));

    // One chip per stored bit, parity chip at PARITY_POS
    for (genvar i = 0; i < STORED_BITS; i++) begin : g_chip
      static_ram_16kx1 u_chip (
        .clk     (clk),
        .reset_n (reset_n),
        .address (chip_addr),
        .ce_n    (bank_ce_n[b]),
        .d       (store_data[i]),
        .w_n     (w_n),
        .q       (bank_q[b][i])
      );
    end

  end

  // Deselected chips drive 0, so a plain OR picks the active bank
  always_comb begin
    load_data = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      load_data = load_data | bank_q[b];
    end
  end

endmodule

// File: memory_controller.sv
//######################################
// rd/wr strobes taken only while ready is high, rd wins a tie.
// Fixed read latency of 2 edges, one read in flight
//######################################
`timescale 1ns/1ps

module memory_controller #(
  parameter int BANK_SEL_BITS = mem_geometry_pkg::BANK_SEL_BITS_DEFAULT
) (
  input  logic                                                clk,
  input  logic                                                reset_n,
  input  logic                                                rd,
  input  logic                                                wr,
  input  logic [BANK_SEL_BITS+mem_geometry_pkg::CHIP_ADDR_BITS-1:0] addr,
  input  mem_word_pkg::word_t                                 wdata,
  input  logic                                                force_bad_parity,
  output logic                                                ready,
  output mem_word_pkg::word_t                                 rdata,
  output logic                                                rvalid,
  output logic                                                parity_error,
  output mem_geometry_pkg::chip_addr_t                        chip_addr,
  output logic [BANK_SEL_BITS-1:0]                            bank_sel,
  output logic                                                ce_n,
  output logic                                                w_n,
  output mem_word_pkg::stored_word_t                          store_data,
  input  mem_word_pkg::stored_word_t                          load_data
);

  import mem_geometry_pkg::*;
  import mem_word_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,      // Free, writes go straight out
    S_RD_ACCESS, // Chips latch the read bit
    S_RD_HOLD    // Gated output visible, capture it
  } state_t;

  state_t state;
  logic   accept_rd;  // Read taken this edge
  logic   accept_wr;  // Write taken this edge
  logic   parity_bit; // Stored parity for the incoming word

  assign ready     = (state == S_IDLE);
  assign accept_rd = ready & rd;
  assign accept_wr = ready & wr & ~rd; // rd has priority

  // Odd parity, flipped on request for diagnostics
  assign parity_bit = ~(^wdata) ^ force_bad_parity;

  // Control sequence
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state        <= S_IDLE;
      ce_n         <= 1'b1;
      w_n          <= 1'b1;
      rvalid       <= 1'b0;
      parity_error <= 1'b0;
    end else begin
      rvalid       <= 1'b0; // Single cycle pulses
      parity_error <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept_rd) begin
            state <= S_RD_ACCESS;
            ce_n  <= 1'b0;
            w_n   <= 1'b1;
          end else if (accept_wr) begin
            ce_n <= 1'b0; // Chips write on the next edge
            w_n  <= 1'b0;
          end else begin
            ce_n <= 1'b1;
            w_n  <= 1'b1;
          end
        end
        S_RD_ACCESS: begin
          state <= S_RD_HOLD; // Keep ce_n low so q stays gated on
        end
        S_RD_HOLD: begin
          state  <= S_IDLE;
          ce_n   <= 1'b1;
          rvalid <= 1'b1;
          // Even count of ones across all 17 bits breaks odd parity
          parity_error <= ~(^load_data);
        end
        default: begin
          state <= S_IDLE;
          ce_n  <= 1'b1;
          w_n   <= 1'b1;
        end
      endcase
    end
  end

  // Address and data registers
  always_ff @(posedge clk) begin
    if (accept_rd || accept_wr) begin
      chip_addr <= addr[CHIP_ADDR_BITS-1:0];
      bank_sel  <= addr[CHIP_ADDR_BITS +: BANK_SEL_BITS]; // High bits pick bank
    end
    if (accept_wr) begin
      store_data[WORD_BITS-1:0] <= wdata;
      store_data[PARITY_POS]    <= parity_bit;
    end
    if (state == S_RD_HOLD) begin
      rdata <= load_data[WORD_BITS-1:0]; // Parity bit dropped
    end
  end

endmodule

// File: parity_memory_top.sv
//######################################
// Parity memory, controller plus bank array.
// NUM_BANKS must not exceed 2**BANK_SEL_BITS
//######################################
`timescale 1ns/1ps

module parity_memory_top #(
  parameter int NUM_BANKS     = mem_geometry_pkg::NUM_BANKS_DEFAULT,
  parameter int BANK_SEL_BITS = mem_geometry_pkg::BANK_SEL_BITS_DEFAULT
) (
  input  logic                                                clk,
  input  logic                                                reset_n,
  input  logic                                                rd,
  input  logic                                                wr,
  input  logic [BANK_SEL_BITS+mem_geometry_pkg::CHIP_ADDR_BITS-1:0] addr,
  input  mem_word_pkg::word_t                                 wdata,
  input  logic                                                force_bad_parity,
  output logic                                                ready,
  output mem_word_pkg::word_t                                 rdata,
  output logic                                                rvalid,
  output logic                                                parity_error
);

  import mem_geometry_pkg::*;
  import mem_word_pkg::*;

  // Chip side of the controller
  chip_addr_t               chip_addr;
  logic [BANK_SEL_BITS-1:0] bank_sel;
  logic                     ce_n;
  logic                     w_n;
  stored_word_t             store_data; // Word plus parity to the chips
  stored_word_t             load_data;  // Gated bank output

  memory_controller #(
    .BANK_SEL_BITS (BANK_SEL_BITS)
  ) u_controller (
    .clk              (clk),
    .reset_n          (reset_n),
    .rd               (rd),
    .wr               (wr),
    .addr             (addr),
    .wdata            (wdata),
    .force_bad_parity (force_bad_parity),
    .ready            (ready),
    .rdata            (rdata),
    .rvalid           (rvalid),
    .parity_error     (parity_error),
    .chip_addr        (chip_addr),
    .bank_sel         (bank_sel),
    .ce_n             (ce_n),
    .w_n              (w_n),
    .store_data       (store_data),
    .load_data        (load_data)
  );

  memory_bank_array #(
    .NUM_BANKS     (NUM_BANKS),
    .BANK_SEL_BITS (BANK_SEL_BITS)
  ) u_array (
    .clk        (clk),
    .reset_n    (reset_n),
    .chip_addr  (chip_addr),
    .bank_sel   (bank_sel),
    .ce_n       (ce_n),
    .w_n        (w_n),
    .store_data (store_data),
    .load_data  (load_data)
  );

endmodule

// File: memory_assertions.sv
//########################################
// Bound to memory_controller, sees its ports only.
// Idle while reset_n is low
//########################################
`timescale 1ns/1ps

module memory_assertions (
  input logic clk,
  input logic reset_n,
  input logic rd,
  input logic wr,
  input logic ready,
  input logic ce_n,
  input logic rvalid,
  input logic parity_error
);

  // Idle with no strobe leaves every chip deselected
  property idle_deselects;
    @(posedge clk) disable iff (!reset_n)
      ready && !rd && !wr |=> ce_n;
  endproperty

  // Accepted read, rvalid exactly 2 edges later
  property read_latency;
    @(posedge clk) disable iff (!reset_n)
      ready && rd |=> !rvalid ##1 !rvalid ##1 rvalid;
  endproperty

  property error_needs_valid;
    @(posedge clk) disable iff (!reset_n)
      parity_error |-> rvalid; // Flag only rides with read data
  endproperty

  assert property (idle_deselects) else $error("ce_n low with no accepted strobe");
  assert property (read_latency) else $error("rvalid not 2 edges after accepted rd");
  assert property (error_needs_valid) else $error("parity_error without rvalid");

endmodule

bind memory_controller memory_assertions u_assertions (
  .clk          (clk),
  .reset_n      (reset_n),
  .rd           (rd),
  .wr           (wr),
  .ready        (ready),
  .ce_n         (ce_n),
  .rvalid       (rvalid),
  .parity_error (parity_error)
);

// File: tb_parity_memory.sv
//########################################
// Testbench for parity_memory_top with 4 banks. Reads only
// hit addresses written earlier since the array has no reset
//########################################
`timescale 1ns/1ps

module tb_parity_memory;

  import mem_geometry_pkg::*;
  import mem_word_pkg::*;

  localparam int          NUM_BANKS     = 4;
  localparam int          BANK_SEL_BITS = 2;
  localparam int          ADDR_BITS     = BANK_SEL_BITS + CHIP_ADDR_BITS;
  localparam int          CLK_PERIOD    = 100; // ns
  localparam int          RESET_CYCLES  = 2;
  localparam logic [31:0] SEED          = 32'd22;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef enum int {OP_WRITE, OP_READ, OP_BUSY_READ} op_t;
  typedef struct {
    op_t   op;
    addr_t addr;
    word_t data;     // Write data or data of the wr dropped while busy
    logic  fbp;      // force_bad_parity on writes
    word_t exp_data;
    logic  exp_perr;
  } row_t;

  logic  clk;
  logic  reset_n;
  logic  rd;
  logic  wr;
  addr_t addr;
  word_t wdata;
  logic  force_bad_parity;
  logic  ready;
  word_t rdata;
  logic  rvalid;
  logic  parity_error;

  row_t        table_q [$];
  word_t       model_data [addr_t]; // Expected word per address
  logic        model_perr [addr_t]; // Expected parity_error per address
  logic [31:0] rng_state;
  bit          table_built;
  int          check_count;
  int          error_count;

  parity_memory_top #(
    .NUM_BANKS     (NUM_BANKS),
    .BANK_SEL_BITS (BANK_SEL_BITS)
  ) DUT (
    .clk              (clk),
    .reset_n          (reset_n),
    .rd               (rd),
    .wr               (wr),
    .addr             (addr),
    .wdata            (wdata),
    .force_bad_parity (force_bad_parity),
    .ready            (ready),
    .rdata            (rdata),
    .rvalid           (rvalid),
    .parity_error     (parity_error)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic addr_t make_addr(input int bank, input chip_addr_t chip);
    return {BANK_SEL_BITS'(bank), chip}; // Bank index on top
  endfunction

  function automatic string op_name(input op_t op);
    case (op)
      OP_WRITE: return "write";
      OP_READ:  return "read";
      default:  return "read+busy wr";
    endcase
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  // Model follows every write that will really land
  task automatic add_write(input addr_t a, input word_t d, input logic fbp);
    row_t r;
    r = '{OP_WRITE, a, d, fbp, '0, 1'b0};
    table_q.push_back(r);
    model_data[a] = d;
    model_perr[a] = fbp; // Bad parity sticks until rewritten
  endtask

  task automatic add_read(input addr_t a, input op_t op, input word_t busy_data);
    row_t r;
    r = '{op, a, busy_data, 1'b0, model_data[a], model_perr[a]};
    table_q.push_back(r); // Busy wr stays out of the model since it must be dropped
  endtask

  task automatic build_table();
    addr_t written [$];
    addr_t a;
    // Three random words per bank, then read back
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int k = 0; k < 3; k++) begin
        rng_state = xorshift32(rng_state);
        a = make_addr(b, rng_state[CHIP_ADDR_BITS-1:0]);
        rng_state = xorshift32(rng_state);
        add_write(a, rng_state[31:16], 1'b0);
        written.push_back(a);
      end
    end
    foreach (written[i]) begin
      add_read(written[i], OP_READ, '0);
    end
    // Same chip address in bank 0 and bank 3 stays independent
    add_write(make_addr(3, 14'h0123), 16'hA5C3, 1'b0);
    add_write(make_addr(0, 14'h0123), 16'h3C5A, 1'b0);
    add_read(make_addr(3, 14'h0123), OP_READ, '0);
    add_read(make_addr(0, 14'h0123), OP_READ, '0);
    // Forced bad parity is cleared by a clean rewrite
    add_write(make_addr(1, 14'h0456), 16'h1234, 1'b1);
    add_read(make_addr(1, 14'h0456), OP_READ, '0);
    add_write(make_addr(1, 14'h0456), 16'h1234, 1'b0);
    add_read(make_addr(1, 14'h0456), OP_READ, '0);
    // wr during a read is ignored
    add_write(make_addr(2, 14'h2222), 16'h0F0F, 1'b0);
    add_read(make_addr(2, 14'h2222), OP_BUSY_READ, 16'hDEAD);
    add_read(make_addr(2, 14'h2222), OP_READ, '0);
    // Back to back writes on consecutive cycles
    for (int k = 0; k < 4; k++) begin
      rng_state = xorshift32(rng_state);
      add_write(make_addr(2, chip_addr_t'(14'h1000 + k)), rng_state[15:0], 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      add_read(make_addr(2, chip_addr_t'(14'h1000 + k)), OP_READ, '0);
    end
  endtask

  // Leaves wr high so the next row's first edge accepts it
  task automatic run_write(input row_t r);
    @(posedge clk);
    #1;
    rd               = 1'b0;
    wr               = 1'b1;
    addr             = r.addr;
    wdata            = r.data;
    force_bad_parity = r.fbp;
    @(negedge clk);
    check_flag("ready", ready, 1'b1);
  endtask

  task automatic run_read(input row_t r);
    int edges;
    @(posedge clk);
    #1;
    rd               = 1'b1;
    wr               = 1'b0;
    addr             = r.addr;
    force_bad_parity = 1'b0;
    @(negedge clk);
    check_flag("ready", ready, 1'b1);
    @(posedge clk);    // rd accepted here
    #1;
    rd    = 1'b0;
    wr    = (r.op == OP_BUSY_READ); // Same address, held through both busy edges
    wdata = r.data;
    @(negedge clk);
    check_flag("ready", ready, 1'b0);
    check_flag("rvalid", rvalid, 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_flag("ready", ready, 1'b0);
    check_flag("rvalid", rvalid, 1'b0);
    @(posedge clk);    // Second busy edge, read data registered
    #1;
    wr = 1'b0;
    @(negedge clk);
    edges = 3;
    while (!rvalid && edges < 8) begin
      @(negedge clk);
      edges++;
    end
    if (!rvalid) begin
      error_count++;
      $display("rvalid never arrived after the read was accepted");
    end else if (edges != 3) begin
      error_count++;
      $display("rvalid came %0d edges after the read, expected 2", edges - 1);
    end else begin
      check_word("rdata", rdata, r.exp_data);
      check_flag("parity_error", parity_error, r.exp_perr);
    end
  endtask

  task automatic report_test(input int idx, input string what, input int errs_before);
    $display("test %0d %s: %s", idx, what, (error_count == errs_before) ? "ok" : "errors");
  endtask

  // Watchdog allows about 6 cycles per row plus reset
  initial begin
    wait (table_built);
    #((table_q.size() * 6 + RESET_CYCLES + 4) * CLK_PERIOD);
    $display("Timeout: the test table did not finish in the expected time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    int errs;
    clk              = 1'b0;
    reset_n          = 1'b0;
    rd               = 1'b0;
    wr               = 1'b0;
    addr             = '0;
    wdata            = '0;
    force_bad_parity = 1'b0;
    rng_state        = SEED;
    check_count      = 0;
    error_count      = 0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(negedge clk);
    check_flag("ready", ready, 1'b1);
    check_flag("rvalid", rvalid, 1'b0);
    check_flag("parity_error", parity_error, 1'b0);
    report_test(0, "reset", 0);
    foreach (table_q[i]) begin
      errs = error_count;
      if (table_q[i].op == OP_WRITE) begin
        run_write(table_q[i]);
      end else begin
        run_read(table_q[i]);
      end
      report_test(i + 1, $sformatf("%s addr %h", op_name(table_q[i].op), table_q[i].addr), errs);
    end
    @(posedge clk);
    #1;
    rd = 1'b0;
    wr = 1'b0; // Last write lands on this edge
    repeat (2) @(posedge clk);
    $display("%0d tests, %0d checks, %0d errors", table_q.size() + 1, check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: files.f
mem_geometry_pkg.sv
mem_word_pkg.sv
static_ram_16kx1.sv
memory_bank_array.sv
memory_controller.sv
parity_memory_top.sv
memory_assertions.sv
tb_parity_memory.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_parity_memory
FILE_LIST := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
